/* Bender.yml */
package:
  name: gpio_mgmt

sources:
  - files:
      - hw/gpio_cfg_pkg.sv
      - hw/gpio_ctrl_regs.sv
      - hw/gpio_serial_loader.sv
      - hw/gpio_pad_cfg_chain.sv
      - hw/gpio_mgmt_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_gpio_mgmt.sv

/* files.f */
+incdir+verif
hw/gpio_cfg_pkg.sv
hw/gpio_ctrl_regs.sv
hw/gpio_serial_loader.sv
hw/gpio_pad_cfg_chain.sv
hw/gpio_mgmt_top.sv
verif/tb_gpio_mgmt.sv

/* hw/gpio_cfg_pkg.sv */
package gpio_cfg_pkg;

    localparam int io_pads  = 8;   // Pads under management control
    localparam int cfg_bits = 13;  // One pad configuration word

    // Counter widths for the serial loader
    localparam int pad_idx_w = $clog2(io_pads);
    localparam int bit_idx_w = $clog2(cfg_bits);
    localparam logic [pad_idx_w-1:0] last_pad = pad_idx_w'(io_pads - 1);
    localparam logic [bit_idx_w-1:0] last_bit = bit_idx_w'(cfg_bits - 1);

    // Field positions within a configuration word
    localparam int oeb_bit     = 1;
    localparam int inp_dis_bit = 3;

    localparam logic [31:0] base_adr = 32'h2300_0000;  // Window is bits 31:8
    localparam logic [7:0]  data_ofs = 8'h00;
    localparam logic [7:0]  xfer_ofs = 8'h04;
    localparam logic [7:0]  cfg_ofs  = 8'h08;          // Pad n sits at cfg_ofs + 4n

    localparam logic [cfg_bits-1:0] cfg_default_bidir = 13'h1801;
    localparam logic [cfg_bits-1:0] cfg_default_input = 13'h0403;

    typedef logic [cfg_bits-1:0] pad_cfg_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        we;
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } bus_rsp_t;

    // Pads 0 and 1 reset bidirectional and all others as simple inputs
    function automatic pad_cfg_t cfg_default(int pad);
        if (pad < 2) begin
            return cfg_default_bidir;
        end
        return cfg_default_input;
    endfunction

endpackage

/* hw/gpio_ctrl_regs.sv */
module gpio_ctrl_regs (
    input  logic                              clk,
    input  logic                              resetn,
    input  gpio_cfg_pkg::bus_req_t            req_i,
    input  logic                              req_valid_i,
    output logic                              req_ready_o,
    output gpio_cfg_pkg::bus_rsp_t            rsp_o,
    input  logic [gpio_cfg_pkg::io_pads-1:0]  gpio_in_i,
    output logic [gpio_cfg_pkg::io_pads-1:0]  gpio_out_o,
    output logic [gpio_cfg_pkg::io_pads-1:0]  gpio_outz_o,
    output logic [gpio_cfg_pkg::io_pads-1:0]  gpio_oeb_o,
    input  logic                              busy_i,
    output logic                              xfer_start_o,
    output gpio_cfg_pkg::pad_cfg_t            cfg_o [gpio_cfg_pkg::io_pads]
);

    logic                             accept;
    logic                             in_win;
    logic                             wr_en;
    logic [7:0]                       ofs;
    logic                             data_sel;
    logic                             xfer_sel;
    logic [gpio_cfg_pkg::io_pads-1:0] cfg_sel;
    logic [31:0]                      rd_data;
    logic                             xfer_req;

    assign accept = req_valid_i && !req_ready_o;  // New request not yet acknowledged
    assign in_win = req_i.addr[31:8] == gpio_cfg_pkg::base_adr[31:8];
    assign wr_en  = accept && in_win && req_i.we;
    assign ofs    = req_i.addr[7:0];

    assign data_sel = ofs == gpio_cfg_pkg::data_ofs;
    assign xfer_sel = ofs == gpio_cfg_pkg::xfer_ofs;

    // One word per pad, 4 bytes apart
    always_comb begin
        for (int i = 0; i < gpio_cfg_pkg::io_pads; i++) begin
            cfg_sel[i] = ofs == gpio_cfg_pkg::cfg_ofs + 8'(4 * i);
        end
    end

    // Unmapped offsets and foreign windows read as zero
    always_comb begin
        rd_data = '0;
        if (in_win) begin
            if (data_sel) begin
                rd_data[gpio_cfg_pkg::io_pads-1:0] = gpio_in_i;
            end else if (xfer_sel) begin
                rd_data[0] = busy_i;
            end
            for (int i = 0; i < gpio_cfg_pkg::io_pads; i++) begin
                if (cfg_sel[i]) begin
                    rd_data[gpio_cfg_pkg::cfg_bits-1:0] = cfg_o[i];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            req_ready_o  <= 1'b0;
            xfer_req     <= 1'b0;
            xfer_start_o <= 1'b0;
            gpio_out_o   <= '0;
        end else begin
            req_ready_o  <= accept;  // Every request gets one acknowledge
            xfer_req     <= wr_en && xfer_sel && req_i.wdata[0];
            xfer_start_o <= xfer_req && !busy_i;  // Dropped while a transfer runs
            if (wr_en && data_sel) begin
                gpio_out_o <= req_i.wdata[gpio_cfg_pkg::io_pads-1:0];
            end
        end
    end

    // Read data is held until the next request
    always_ff @(posedge clk) begin
        if (accept) begin
            rsp_o.rdata <= rd_data;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < gpio_cfg_pkg::io_pads; i++) begin
                cfg_o[i] <= gpio_cfg_pkg::cfg_default(i);
            end
        end else begin
            for (int i = 0; i < gpio_cfg_pkg::io_pads; i++) begin
                if (wr_en && cfg_sel[i]) begin
                    cfg_o[i] <= req_i.wdata[gpio_cfg_pkg::cfg_bits-1:0];
                end
            end
        end
    end

    // OEB goes out directly as well as through the serial chain
    for (genvar i = 0; i < gpio_cfg_pkg::io_pads; i++) begin : g_pad
        assign gpio_oeb_o[i]  = cfg_o[i][gpio_cfg_pkg::oeb_bit];
        assign gpio_outz_o[i] = cfg_o[i][gpio_cfg_pkg::inp_dis_bit] ? gpio_out_o[i] : 1'bz;
    end

    // Master keeps the request up and unchanged until the acknowledge
    a_req_hold: assert property (
        @(posedge clk) disable iff (!resetn)
        req_valid_i && !req_ready_o |=> req_valid_i && $stable(req_i)
    );

    // Loader busy feeds back from another module
    a_start_idle: assert property (
        @(posedge clk) disable iff (!resetn)
        xfer_start_o |-> !busy_i
    );

endmodule

/* hw/gpio_mgmt_top.sv */
module gpio_mgmt_top (
    input  logic                              clk,
    input  logic                              resetn,
    input  gpio_cfg_pkg::bus_req_t            req_i,
    input  logic                              req_valid_i,
    output logic                              req_ready_o,
    output gpio_cfg_pkg::bus_rsp_t            rsp_o,
    input  logic [gpio_cfg_pkg::io_pads-1:0]  gpio_in_i,
    output logic [gpio_cfg_pkg::io_pads-1:0]  gpio_out_o,
    output logic [gpio_cfg_pkg::io_pads-1:0]  gpio_outz_o,
    output logic [gpio_cfg_pkg::io_pads-1:0]  gpio_oeb_o,
    output logic                              serial_clock_o,
    output logic                              serial_resetn_o,
    output logic                              serial_data_o,
    output gpio_cfg_pkg::pad_cfg_t            pad_cfg_o [gpio_cfg_pkg::io_pads]
);

    logic                   xfer_start;
    logic                   busy;
    gpio_cfg_pkg::pad_cfg_t cfg [gpio_cfg_pkg::io_pads];  // Register file copy of all pads

    gpio_ctrl_regs u_regs (
        .clk          (clk),
        .resetn       (resetn),
        .req_i        (req_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .rsp_o        (rsp_o),
        .gpio_in_i    (gpio_in_i),
        .gpio_out_o   (gpio_out_o),
        .gpio_outz_o  (gpio_outz_o),
        .gpio_oeb_o   (gpio_oeb_o),
        .busy_i       (busy),
        .xfer_start_o (xfer_start),
        .cfg_o        (cfg)
    );

    gpio_serial_loader u_loader (
        .clk             (clk),
        .resetn          (resetn),
        .xfer_start_i    (xfer_start),
        .cfg_i           (cfg),
        .busy_o          (busy),
        .serial_clock_o  (serial_clock_o),
        .serial_resetn_o (serial_resetn_o),
        .serial_data_o   (serial_data_o)
    );

    gpio_pad_cfg_chain u_chain (
        .clk             (clk),
        .resetn          (resetn),
        .serial_clock_i  (serial_clock_o),
        .serial_resetn_i (serial_resetn_o),
        .serial_data_i   (serial_data_o),
        .pad_cfg_o       (pad_cfg_o)
    );

endmodule

/* hw/gpio_pad_cfg_chain.sv */
module gpio_pad_cfg_chain (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   serial_clock_i,
    input  logic                   serial_resetn_i,
    input  logic                   serial_data_i,
    output gpio_cfg_pkg::pad_cfg_t pad_cfg_o [gpio_cfg_pkg::io_pads]
);

    logic sclk_q;
    logic sclk_prev;
    logic srn_q;
    logic srn_prev;
    logic sdata_q;
    logic sclk_rise;
    logic load_strobe;
    logic [gpio_cfg_pkg::io_pads*gpio_cfg_pkg::cfg_bits-1:0] chain_q;

    // Serial lines come from another clock region in a real chip
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            sclk_q    <= 1'b0;
            sclk_prev <= 1'b0;
            srn_q     <= 1'b0;
            srn_prev  <= 1'b0;
        end else begin
            sclk_q    <= serial_clock_i;
            sclk_prev <= sclk_q;
            srn_q     <= serial_resetn_i;
            srn_prev  <= srn_q;
        end
    end

    assign sclk_rise   = sclk_q && !sclk_prev;
    assign load_strobe = srn_prev && !srn_q && sclk_q;  // Reset falls while clock is high

    // First bit sent ends up at the top of the chain
    always_ff @(posedge clk) begin
        sdata_q <= serial_data_i;
        if (sclk_rise) begin
            chain_q <= {chain_q[gpio_cfg_pkg::io_pads*gpio_cfg_pkg::cfg_bits-2:0], sdata_q};
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < gpio_cfg_pkg::io_pads; i++) begin
                pad_cfg_o[i] <= gpio_cfg_pkg::cfg_default(i);
            end
        end else if (load_strobe) begin
            for (int i = 0; i < gpio_cfg_pkg::io_pads; i++) begin
                pad_cfg_o[i] <= chain_q[i*gpio_cfg_pkg::cfg_bits +: gpio_cfg_pkg::cfg_bits];
            end
        end
    end

    // Loader must settle data on the falling edge before each rise
    a_data_stable: assert property (
        @(posedge clk) disable iff (!resetn)
        $rose(serial_clock_i) |-> $stable(serial_data_i)
    );

endmodule

/* hw/gpio_serial_loader.sv */
module gpio_serial_loader (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   xfer_start_i,
    input  gpio_cfg_pkg::pad_cfg_t cfg_i [gpio_cfg_pkg::io_pads],
    output logic                   busy_o,
    output logic                   serial_clock_o,
    output logic                   serial_resetn_o,
    output logic                   serial_data_o
);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_shift,
        st_load
    } state_t;

    state_t                             state;
    logic [gpio_cfg_pkg::pad_idx_w-1:0] pad_cnt;
    logic [gpio_cfg_pkg::bit_idx_w-1:0] bit_cnt;
    logic [gpio_cfg_pkg::pad_idx_w-1:0] word_idx;
    gpio_cfg_pkg::pad_cfg_t             staging;
    logic                               clk_high;
    logic                               load_word;
    logic                               shift_word;

    assign busy_o        = state != st_idle;
    assign serial_data_o = staging[gpio_cfg_pkg::cfg_bits-1];  // MSB first

    // Highest pad goes first
    assign word_idx = (state == st_idle) ? gpio_cfg_pkg::last_pad : pad_cnt - 1'b1;

    // Clock is high in shift, so it falls next unless this is the very last bit
    assign clk_high   = (state == st_shift) && serial_clock_o;
    assign load_word  = (state == st_idle && xfer_start_i) ||
                        (clk_high && bit_cnt == gpio_cfg_pkg::last_bit && pad_cnt != '0);
    assign shift_word = clk_high && bit_cnt != gpio_cfg_pkg::last_bit;

    always_ff @(posedge clk) begin
        if (load_word) begin
            staging <= cfg_i[word_idx];
        end else if (shift_word) begin
            staging <= {staging[gpio_cfg_pkg::cfg_bits-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state           <= st_idle;
            pad_cnt         <= '0;
            bit_cnt         <= '0;
            serial_clock_o  <= 1'b0;
            serial_resetn_o <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    serial_clock_o  <= 1'b0;
                    serial_resetn_o <= 1'b1;
                    if (xfer_start_i) begin
                        pad_cnt <= gpio_cfg_pkg::last_pad;
                        state   <= st_start;
                    end
                end
                st_start: begin
                    bit_cnt <= '0;
                    state   <= st_shift;
                end
                st_shift: begin
                    if (!serial_clock_o) begin
                        serial_clock_o <= 1'b1;  // Rising edge, data held
                    end else if (bit_cnt != gpio_cfg_pkg::last_bit) begin
                        serial_clock_o <= 1'b0;
                        bit_cnt        <= bit_cnt + 1'b1;
                    end else if (pad_cnt != '0) begin
                        serial_clock_o <= 1'b0;
                        pad_cnt        <= pad_cnt - 1'b1;
                        state          <= st_start;
                    end else begin
                        bit_cnt <= '0;  // Clock stays high into the load phase
                        state   <= st_load;
                    end
                end
                st_load: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    case (bit_cnt)
                        0:       serial_resetn_o <= 1'b0;  // Load strobe with clock high
                        1:       serial_resetn_o <= 1'b1;
                        2:       serial_clock_o  <= 1'b0;
                        default: state           <= st_idle;
                    endcase
                end
                default: state <= st_idle;
            endcase
        end
    end

    a_idle_clock_low: assert property (
        @(posedge clk) disable iff (!resetn)
        (state == st_idle) |-> !serial_clock_o
    );

endmodule

/* verif/tb_gpio_mgmt_util.svh */
`ifndef TB_GPIO_MGMT_UTIL_SVH
`define TB_GPIO_MGMT_UTIL_SVH

// Valid is held until the slave acknowledges the request
task automatic issue_request(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic we, output logic [31:0] rdata);
    @(posedge clk);
    #2;
    req.addr  = addr;
    req.wdata = wdata;
    req.we    = we;
    req_valid = 1'b1;
    do begin
        @(posedge clk);
    end while (!req_ready);
    rdata = rsp.rdata;  // Valid in the ready cycle
    #2;
    req_valid = 1'b0;
endtask

task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] ignored;
    int          idx;
    issue_request(addr, data, 1'b1, ignored);
    idx = cfg_index(addr);
    if (idx >= 0) begin
        shadow[idx] = data[gpio_cfg_pkg::cfg_bits-1:0];
    end
    if (addr == base + 32'(gpio_cfg_pkg::data_ofs)) begin
        out_shadow = data[pads-1:0];
    end
endtask

task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
    issue_request(addr, 32'h0, 1'b0, data);
endtask

function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        $display("Checks failed");
        $fatal(1, "Stopping at first mismatch");
    end
endtask

// Pads 0 and 1 come up bidirectional and the rest as inputs
function automatic gpio_cfg_pkg::pad_cfg_t default_cfg(input int pad);
    return (pad < 2) ? 13'h1801 : 13'h0403;
endfunction

// Pad driven only where its input-disable bit is set
function automatic logic [pads-1:0] expected_outz(input logic [pads-1:0] out);
    logic [pads-1:0] res;
    for (int i = 0; i < pads; i++) begin
        res[i] = shadow[i][gpio_cfg_pkg::inp_dis_bit] ? out[i] : 1'bz;
    end
    return res;
endfunction

`endif

/* verif/tb_gpio_mgmt.sv */
module tb_gpio_mgmt;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          pads           = gpio_cfg_pkg::io_pads;
    localparam int          timeout_cycles = 2000;  // About eight times one transfer with polling
    localparam logic [31:0] base           = gpio_cfg_pkg::base_adr;
    localparam logic [31:0] other_win      = 32'h2301_0008;
    localparam logic [31:0] unmapped       = gpio_cfg_pkg::base_adr + 32'h40;

    logic                   clk;
    logic                   resetn;
    gpio_cfg_pkg::bus_req_t req;
    logic                   req_valid;
    logic                   req_ready;
    gpio_cfg_pkg::bus_rsp_t rsp;
    logic [pads-1:0]        gpio_in;
    logic [pads-1:0]        gpio_out;
    logic [pads-1:0]        gpio_outz;
    logic [pads-1:0]        gpio_oeb;
    logic                   serial_clock;
    logic                   serial_resetn;
    logic                   serial_data;
    gpio_cfg_pkg::pad_cfg_t pad_cfg [pads];

    gpio_cfg_pkg::pad_cfg_t shadow [pads];  // Expected contents of every config word
    logic [pads-1:0]        out_shadow;
    logic [31:0]            rng_state   = 32'h841f1c36;
    int                     cycle_count = 0;
    int                     edge_count  = 0;
    logic                   sclk_prev   = 1'b0;
    logic [pads*gpio_cfg_pkg::cfg_bits-1:0] sent_bits = '0;  // Serial data seen at each rise

    `include "tb_gpio_mgmt_util.svh"

    gpio_mgmt_top UUT (
        .clk             (clk),
        .resetn          (resetn),
        .req_i           (req),
        .req_valid_i     (req_valid),
        .req_ready_o     (req_ready),
        .rsp_o           (rsp),
        .gpio_in_i       (gpio_in),
        .gpio_out_o      (gpio_out),
        .gpio_outz_o     (gpio_outz),
        .gpio_oeb_o      (gpio_oeb),
        .serial_clock_o  (serial_clock),
        .serial_resetn_o (serial_resetn),
        .serial_data_o   (serial_data),
        .pad_cfg_o       (pad_cfg)
    );

    function automatic int cfg_index(input logic [31:0] addr);
        int ofs;
        ofs = int'(addr[7:0]) - int'(gpio_cfg_pkg::cfg_ofs);
        if (addr[31:8] != base[31:8] || ofs < 0 || ofs % 4 != 0 || ofs / 4 >= pads) begin
            return -1;
        end
        return ofs / 4;
    endfunction

    function automatic logic [31:0] cfg_addr(input int pad);
        return base + 32'(gpio_cfg_pkg::cfg_ofs) + 32'(4 * pad);
    endfunction

    // Reference read model that leaves busy to the polling loop
    function automatic logic [31:0] expected_read(input logic [31:0] addr);
        int idx;
        idx = cfg_index(addr);
        if (idx >= 0) begin
            return 32'(shadow[idx]);
        end
        if (addr == base + 32'(gpio_cfg_pkg::data_ofs)) begin
            return 32'(gpio_in);
        end
        return 32'h0;
    endfunction

    function automatic logic [31:0] read_mask(input logic [31:0] addr);
        return (addr == base + 32'(gpio_cfg_pkg::xfer_ofs)) ? 32'hffff_fffe : 32'hffff_ffff;
    endfunction

    function automatic logic [pads-1:0] expected_oeb();
        logic [pads-1:0] res;
        for (int i = 0; i < pads; i++) begin
            res[i] = shadow[i][gpio_cfg_pkg::oeb_bit];
        end
        return res;
    endfunction

    task automatic check_pad_cfg();
        for (int i = 0; i < pads; i++) begin
            check_value($sformatf("pad_cfg_o[%0d]", i), pad_cfg[i], shadow[i]);
        end
    endtask

    task automatic run_transfer();
        logic [31:0] rdata;
        edge_count = 0;
        sent_bits  = '0;
        write_reg(base + 32'(gpio_cfg_pkg::xfer_ofs), 32'h1);
        do begin
            read_reg(base + 32'(gpio_cfg_pkg::xfer_ofs), rdata);
        end while (rdata[0]);  // Busy low marks the end
        check_pad_cfg();
        check_value("serial_clock_o rising edges", edge_count, pads * gpio_cfg_pkg::cfg_bits);
        // Highest pad goes out first and pad 0 last, MSB first
        for (int i = 0; i < pads; i++) begin
            check_value($sformatf("serial_data_o word %0d", i),
                        sent_bits[i*gpio_cfg_pkg::cfg_bits +: gpio_cfg_pkg::cfg_bits],
                        shadow[i]);
        end
    endtask

    always #20 clk = ~clk;

    // Every read response against the reference
    always @(posedge clk) begin
        if (resetn && req_valid && req_ready && !req.we) begin
            check_value("rsp_o.rdata", rsp.rdata & read_mask(req.addr), expected_read(req.addr));
        end
    end

    always @(posedge clk) begin
        if (serial_clock && !sclk_prev) begin
            edge_count++;
            sent_bits = {sent_bits[pads*gpio_cfg_pkg::cfg_bits-2:0], serial_data};
        end
        sclk_prev = serial_clock;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d clock cycles", timeout_cycles);
            $display("Checks failed");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    initial begin
        logic [31:0] rdata;
        logic [31:0] value;
        clk        = 1'b0;
        resetn     = 1'b0;
        req        = '0;
        req_valid  = 1'b0;
        gpio_in    = '0;
        out_shadow = '0;
        for (int i = 0; i < pads; i++) begin
            shadow[i] = default_cfg(i);
        end
        repeat (5) @(posedge clk);
        #2;
        resetn = 1'b1;

        // Reset state
        for (int i = 0; i < pads; i++) begin
            read_reg(cfg_addr(i), rdata);
        end
        check_value("gpio_out_o", gpio_out, out_shadow);
        check_value("gpio_oeb_o", gpio_oeb, expected_oeb());
        check_pad_cfg();
        check_value("serial_clock_o", serial_clock, 1'b0);
        check_value("serial_resetn_o", serial_resetn, 1'b1);
        read_reg(base + 32'(gpio_cfg_pkg::xfer_ofs), rdata);
        check_value("xfer busy", rdata[0], 1'b0);

        // Configuration words
        for (int i = 0; i < pads; i++) begin
            write_reg(cfg_addr(i), next_random());
        end
        for (int i = 0; i < pads; i++) begin
            read_reg(cfg_addr(i), rdata);
        end
        check_value("gpio_oeb_o", gpio_oeb, expected_oeb());

        // Data word and pad drive
        value = next_random();
        write_reg(base + 32'(gpio_cfg_pkg::data_ofs), value);
        check_value("gpio_out_o", gpio_out, value[pads-1:0]);
        value = next_random();
        gpio_in = value[pads-1:0];
        read_reg(base + 32'(gpio_cfg_pkg::data_ofs), rdata);
        check_value("gpio_outz_o", gpio_outz, expected_outz(out_shadow));

        // Two serial transfers with fresh words before the second
        run_transfer();
        for (int i = 0; i < pads; i++) begin
            write_reg(cfg_addr(i), next_random());
        end
        run_transfer();

        // Foreign window and unmapped offset
        write_reg(other_win, next_random());
        write_reg(unmapped, next_random());
        read_reg(other_win, rdata);
        check_value("out-of-window read", rdata, 32'h0);
        read_reg(unmapped, rdata);
        check_value("unmapped read", rdata, 32'h0);
        for (int i = 0; i < pads; i++) begin
            read_reg(cfg_addr(i), rdata);
        end
        read_reg(base + 32'(gpio_cfg_pkg::data_ofs), rdata);
        check_value("gpio_out_o", gpio_out, out_shadow);
        check_value("gpio_oeb_o", gpio_oeb, expected_oeb());

        $display("All checks passed");
        $finish;
    end

endmodule
